/* common/pkt_rx_pkg.sv */
`default_nettype none

package pkt_rx_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [5:0]  pkt_len_t;
    typedef logic [31:0] crc_t;
    typedef logic [8:0]  gap_cnt_t;
    typedef logic [3:0]  bit_cnt_t;

    // frame limits
    localparam pkt_len_t max_bytes     = 6'd63;
    localparam pkt_len_t min_frame_len = 6'd5;
    localparam pkt_len_t crc_bytes     = 6'd4; // trailing crc, lsb first

    // line timing, scaled down for simulation
    localparam int       clks_per_bit = 16;
    localparam gap_cnt_t gap_clks     = 9'd384; // 24 bit times of silence

    // standard crc-32, reflected form
    localparam crc_t crc_poly = 32'hEDB8_8320;
    localparam crc_t crc_init = 32'hFFFF_FFFF;

endpackage

`default_nettype wire

/* hdl/uart_rx.sv */
`timescale 1ns/1ns
`default_nettype none

module uart_rx (
    input  wire                 i_clk,
    input  wire                 i_n_reset,
    input  wire                 i_serial,
    output logic                o_byte_valid,
    output pkt_rx_pkg::byte_t   o_byte
);

    typedef enum logic [1:0] {
        st_idle,
        st_start,
        st_data,
        st_stop
    } rx_state_t;

    rx_state_t              state;
    logic                   rx_meta;
    logic                   rx_sync;
    pkt_rx_pkg::bit_cnt_t   clk_cnt;
    logic [2:0]             bit_idx;
    pkt_rx_pkg::byte_t      shift_q;
    logic                   bit_tick;

    always_ff @(posedge i_clk or negedge i_n_reset) begin
        if (!i_n_reset) begin
            rx_meta <= 1'b1; // line idles high
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= i_serial;
            rx_sync <= rx_meta;
        end
    end

    assign bit_tick = (clk_cnt == pkt_rx_pkg::bit_cnt_t'(pkt_rx_pkg::clks_per_bit - 1));

    always_ff @(posedge i_clk or negedge i_n_reset) begin
        if (!i_n_reset) begin
            state        <= st_idle;
            clk_cnt      <= '0;
            bit_idx      <= '0;
            o_byte_valid <= 1'b0;
        end else begin
            o_byte_valid <= 1'b0;
            case (state)
                st_idle: begin
                    clk_cnt <= '0;
                    if (!rx_sync) begin
                        state <= st_start;
                    end
                end
                st_start: begin
                    // half bit, minus the sync and detect latency
                    if (clk_cnt == pkt_rx_pkg::bit_cnt_t'(pkt_rx_pkg::clks_per_bit / 2 - 3)) begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        state   <= rx_sync ? st_idle : st_data; // glitch, not a start bit
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                st_data: begin
                    clk_cnt <= bit_tick ? '0 : clk_cnt + 1'b1;
                    if (bit_tick) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= st_stop;
                        end
                    end
                end
                default: begin
                    clk_cnt <= bit_tick ? '0 : clk_cnt + 1'b1;
                    if (bit_tick) begin
                        o_byte_valid <= rx_sync; // framing error drops the byte
                        state        <= st_idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == st_data && bit_tick) begin
            shift_q <= {rx_sync, shift_q[7:1]}; // lsb arrives first
        end
    end

    assign o_byte = shift_q;

endmodule

`default_nettype wire

/* pkt_rx/frame_collector.sv */
`timescale 1ns/1ns
`default_nettype none

module frame_collector (
    input  wire                     i_clk,
    input  wire                     i_n_reset,
    input  wire                     i_byte_valid,
    input  pkt_rx_pkg::byte_t       i_byte,
    input  wire                     i_frame_release,
    input  pkt_rx_pkg::pkt_len_t    i_chk_idx,
    input  pkt_rx_pkg::pkt_len_t    i_rd_idx,
    output logic                    o_frame_done,
    output pkt_rx_pkg::pkt_len_t    o_frame_len,
    output pkt_rx_pkg::byte_t       o_chk_byte,
    output pkt_rx_pkg::byte_t       o_rd_byte,
    output logic                    o_busy
);

    typedef enum logic [1:0] {
        st_idle,
        st_collect,
        st_hold
    } col_state_t;

    col_state_t             state;
    pkt_rx_pkg::pkt_len_t   len_q;
    pkt_rx_pkg::gap_cnt_t   gap_cnt;
    logic                   accept;
    logic                   room;

    // top entry is never written, keeps every 6-bit index in range
    pkt_rx_pkg::byte_t      mem [0:pkt_rx_pkg::max_bytes];

    assign o_frame_done = (state == st_collect) && (gap_cnt == pkt_rx_pkg::gap_clks);
    assign accept       = i_byte_valid && (state != st_hold) && !o_frame_done;
    assign room         = (len_q < pkt_rx_pkg::max_bytes); // overflow bytes are dropped

    always_ff @(posedge i_clk or negedge i_n_reset) begin
        if (!i_n_reset) begin
            state   <= st_idle;
            len_q   <= '0;
            gap_cnt <= '0;
        end else begin
            if (accept) begin
                state   <= st_collect;
                gap_cnt <= pkt_rx_pkg::gap_cnt_t'(1); // accept cycle counts as silent
                if (room) begin
                    len_q <= len_q + 1'b1;
                end
            end else if (o_frame_done) begin
                state <= st_hold;
            end else if (state == st_collect) begin
                gap_cnt <= gap_cnt + 1'b1;
            end else if (state == st_hold && i_frame_release) begin
                state <= st_idle;
                len_q <= '0;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept && room) begin
            mem[len_q] <= i_byte;
        end
    end

    assign o_frame_len = len_q;
    assign o_busy      = (state != st_idle);

    // two independent read ports
    assign o_chk_byte  = mem[i_chk_idx];
    assign o_rd_byte   = mem[i_rd_idx];

endmodule

`default_nettype wire

/* pkt_rx/crc32_engine.sv */
`timescale 1ns/1ns
`default_nettype none

module crc32_engine (
    input  wire                 i_clk,
    input  wire                 i_n_reset,
    input  wire                 i_start,
    input  wire                 i_en,
    input  pkt_rx_pkg::byte_t   i_byte,
    output pkt_rx_pkg::crc_t    o_crc
);

    pkt_rx_pkg::crc_t crc_q;
    pkt_rx_pkg::crc_t crc_next;

    always_comb begin
        crc_next = crc_q ^ {24'd0, i_byte};
        for (int step = 0; step < 8; step++) begin
            if (crc_next[0]) begin
                crc_next = (crc_next >> 1) ^ pkt_rx_pkg::crc_poly;
            end else begin
                crc_next = crc_next >> 1;
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_n_reset) begin
        if (!i_n_reset) begin
            crc_q <= pkt_rx_pkg::crc_init;
        end else if (i_start) begin
            crc_q <= pkt_rx_pkg::crc_init;
        end else if (i_en) begin
            crc_q <= crc_next;
        end
    end

    assign o_crc = ~crc_q; // final xor

endmodule

`default_nettype wire

/* pkt_rx/pkt_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module pkt_checker (
    input  wire                     i_clk,
    input  wire                     i_n_reset,
    input  wire                     i_frame_done,
    input  pkt_rx_pkg::pkt_len_t    i_frame_len,
    input  pkt_rx_pkg::byte_t       i_chk_byte,
    input  wire                     i_pkt_ack,
    output pkt_rx_pkg::pkt_len_t    o_chk_idx,
    output logic                    o_frame_release,
    output logic                    o_pkt_req,
    output pkt_rx_pkg::pkt_len_t    o_pkt_len,
    output logic                    o_pkt_crc_ok
);

    typedef enum logic [2:0] {
        st_idle,
        st_feed,
        st_compare,
        st_offer,
        st_wait_ack_low
    } chk_state_t;

    chk_state_t             state;
    pkt_rx_pkg::pkt_len_t   payload_len;
    pkt_rx_pkg::crc_t       rx_crc;
    pkt_rx_pkg::crc_t       calc_crc;
    logic                   crc_start;
    logic                   crc_en;
    logic                   in_trailer;

    assign payload_len = o_pkt_len - pkt_rx_pkg::crc_bytes;
    assign in_trailer  = (o_chk_idx >= payload_len);
    assign crc_start   = (state == st_idle) && i_frame_done &&
                         (i_frame_len >= pkt_rx_pkg::min_frame_len);
    assign crc_en      = (state == st_feed) && !in_trailer;

    always_ff @(posedge i_clk or negedge i_n_reset) begin
        if (!i_n_reset) begin
            state           <= st_idle;
            o_chk_idx       <= '0;
            o_frame_release <= 1'b0;
            o_pkt_req       <= 1'b0;
            o_pkt_len       <= '0;
            o_pkt_crc_ok    <= 1'b0;
        end else begin
            o_frame_release <= 1'b0;
            case (state)
                st_idle: begin
                    if (crc_start) begin
                        o_pkt_len <= i_frame_len;
                        o_chk_idx <= '0;
                        state     <= st_feed;
                    end else if (i_frame_done) begin
                        o_frame_release <= 1'b1; // too short, drop it
                    end
                end
                st_feed: begin
                    o_chk_idx <= o_chk_idx + 1'b1;
                    if (o_chk_idx == o_pkt_len - 1'b1) begin
                        state <= st_compare;
                    end
                end
                st_compare: begin
                    o_pkt_crc_ok <= (rx_crc == calc_crc);
                    o_pkt_req    <= 1'b1;
                    state        <= st_offer;
                end
                st_offer: begin
                    if (i_pkt_ack) begin
                        o_pkt_req <= 1'b0;
                        state     <= st_wait_ack_low;
                    end
                end
                default: begin
                    if (!i_pkt_ack) begin
                        o_frame_release <= 1'b1;
                        state           <= st_idle;
                    end
                end
            endcase
        end
    end

    // trailing bytes arrive lsb first
    always_ff @(posedge i_clk) begin
        if (state == st_feed && in_trailer) begin
            rx_crc <= {i_chk_byte, rx_crc[31:8]};
        end
    end

    crc32_engine crc0 (
        .i_clk      (i_clk),
        .i_n_reset  (i_n_reset),
        .i_start    (crc_start),
        .i_en       (crc_en),
        .i_byte     (i_chk_byte),
        .o_crc      (calc_crc)
    );

endmodule

`default_nettype wire

/* hdl/pkt_rx_top.sv */
`timescale 1ns/1ns
`default_nettype none

module pkt_rx_top (
    input  wire                     i_clk,
    input  wire                     i_n_reset,
    input  wire                     i_uart_rx,
    input  pkt_rx_pkg::pkt_len_t    i_rd_idx,
    input  wire                     i_pkt_ack,
    output logic                    o_pkt_req,
    output pkt_rx_pkg::pkt_len_t    o_pkt_len,
    output logic                    o_pkt_crc_ok,
    output pkt_rx_pkg::byte_t       o_rd_byte,
    output logic                    o_rx_busy
);

    logic                   byte_valid;
    pkt_rx_pkg::byte_t      rx_byte;
    logic                   frame_done;
    pkt_rx_pkg::pkt_len_t   frame_len;
    logic                   frame_release;
    pkt_rx_pkg::pkt_len_t   chk_idx;
    pkt_rx_pkg::byte_t      chk_byte;

    uart_rx uart_rx0 (
        .i_clk          (i_clk),
        .i_n_reset      (i_n_reset),
        .i_serial       (i_uart_rx),
        .o_byte_valid   (byte_valid),
        .o_byte         (rx_byte)
    );

    frame_collector collector0 (
        .i_clk              (i_clk),
        .i_n_reset          (i_n_reset),
        .i_byte_valid       (byte_valid),
        .i_byte             (rx_byte),
        .i_frame_release    (frame_release),
        .i_chk_idx          (chk_idx),
        .i_rd_idx           (i_rd_idx),
        .o_frame_done       (frame_done),
        .o_frame_len        (frame_len),
        .o_chk_byte         (chk_byte),
        .o_rd_byte          (o_rd_byte),
        .o_busy             (o_rx_busy)
    );

    pkt_checker checker0 (
        .i_clk              (i_clk),
        .i_n_reset          (i_n_reset),
        .i_frame_done       (frame_done),
        .i_frame_len        (frame_len),
        .i_chk_byte         (chk_byte),
        .i_pkt_ack          (i_pkt_ack),
        .o_chk_idx          (chk_idx),
        .o_frame_release    (frame_release),
        .o_pkt_req          (o_pkt_req),
        .o_pkt_len          (o_pkt_len),
        .o_pkt_crc_ok       (o_pkt_crc_ok)
    );

endmodule

`default_nettype wire

/* dv/tb_clk_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen (
    output logic o_clk,
    output logic o_n_reset
);

    initial begin
        o_clk = 1'b0;
        forever #2 o_clk = ~o_clk; // 4 ns period
    end

    initial begin
        o_n_reset = 1'b0;
        repeat (5) @(posedge o_clk);
        #1 o_n_reset = 1'b1;
    end

endmodule

`default_nettype wire

/* dv/tb_pkt_rx.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_pkt_rx;

    localparam int case_words = 1024;
    localparam int max_idle   = pkt_rx_pkg::gap_clks / 2 / pkt_rx_pkg::clks_per_bit; // bit times
    localparam int req_limit  = pkt_rx_pkg::gap_clks + 2 * pkt_rx_pkg::max_bytes;
    localparam int busy_limit = pkt_rx_pkg::gap_clks + 64;

    logic                   clk;
    logic                   n_reset;
    logic                   uart_rx;
    pkt_rx_pkg::pkt_len_t   rd_idx;
    logic                   pkt_ack;
    logic                   pkt_req;
    pkt_rx_pkg::pkt_len_t   pkt_len;
    logic                   pkt_crc_ok;
    pkt_rx_pkg::byte_t      rd_byte;
    logic                   rx_busy;

    pkt_rx_pkg::byte_t      case_mem [0:case_words-1];
    pkt_rx_pkg::byte_t      frame_q [$];
    logic [31:0]            rng;

    tb_clk_gen clk_gen0 (
        .o_clk      (clk),
        .o_n_reset  (n_reset)
    );

    pkt_rx_top dut0 (
        .i_clk          (clk),
        .i_n_reset      (n_reset),
        .i_uart_rx      (uart_rx),
        .i_rd_idx       (rd_idx),
        .i_pkt_ack      (pkt_ack),
        .o_pkt_req      (pkt_req),
        .o_pkt_len      (pkt_len),
        .o_pkt_crc_ok   (pkt_crc_ok),
        .o_rd_byte      (rd_byte),
        .o_rx_busy      (rx_busy)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] seed);
        return seed * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic report_mismatch(input string msg);
        $display("[FAIL] %0t ns: %s", $time, msg);
        $display("Regression failed");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out at %0t ns while waiting for %s", $time, what);
        $display("Regression failed");
        $fatal(1, "stopped on timeout");
    endtask

    task automatic check_len(input pkt_rx_pkg::pkt_len_t got, input pkt_rx_pkg::pkt_len_t exp,
                             input string what);
        if (got !== exp) begin
            report_mismatch($sformatf("%s is %0d, expected %0d", what, got, exp));
        end
    endtask

    task automatic check_byte(input pkt_rx_pkg::byte_t got, input pkt_rx_pkg::byte_t exp,
                              input string what);
        if (got !== exp) begin
            report_mismatch($sformatf("%s is %02h, expected %02h", what, got, exp));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            report_mismatch($sformatf("%s is %b, expected %b", what, got, exp));
        end
    endtask

    // each step lands 1 ns after a rising edge
    task automatic next_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic send_byte(input pkt_rx_pkg::byte_t data);
        uart_rx = 1'b0; // start bit
        next_cycles(pkt_rx_pkg::clks_per_bit);
        for (int i = 0; i < 8; i++) begin
            uart_rx = data[i]; // lsb first
            next_cycles(pkt_rx_pkg::clks_per_bit);
        end
        uart_rx = 1'b1; // stop bit
        next_cycles(pkt_rx_pkg::clks_per_bit);
    endtask

    task automatic send_frame();
        int idle_bits;
        foreach (frame_q[i]) begin
            send_byte(frame_q[i]);
            rng       = lcg_next(rng);
            idle_bits = int'(rng[23:16]) % (max_idle + 1); // always well inside the gap
            next_cycles(idle_bits * pkt_rx_pkg::clks_per_bit);
        end
    endtask

    task automatic wait_reset_done();
        int n;
        n = 0;
        while (n_reset !== 1'b1) begin
            if (n == 20) begin
                report_timeout("the reset to be released");
            end
            next_cycles(1);
            n++;
        end
    endtask

    task automatic wait_req(input logic level, input string what);
        int n;
        n = 0;
        while (pkt_req !== level) begin
            if (n == req_limit) begin
                report_timeout(what);
            end
            next_cycles(1);
            n++;
        end
    endtask

    task automatic wait_busy_low(input string what);
        int n;
        n = 0;
        while (rx_busy !== 1'b0) begin
            if (n == busy_limit) begin
                report_timeout(what);
            end
            check_flag(pkt_req, 1'b0, "o_pkt_req with no frame on offer");
            next_cycles(1);
            n++;
        end
    endtask

    task automatic offer_and_ack(input logic exp_ok);
        wait_req(1'b1, "o_pkt_req to rise");
        check_len(pkt_len, pkt_rx_pkg::pkt_len_t'(frame_q.size()), "o_pkt_len");
        check_flag(pkt_crc_ok, exp_ok, "o_pkt_crc_ok");
        check_flag(rx_busy, 1'b1, "o_rx_busy while a frame is on offer");
        foreach (frame_q[i]) begin
            rd_idx = pkt_rx_pkg::pkt_len_t'(i);
            #1; // read port is combinational
            check_byte(rd_byte, frame_q[i], $sformatf("o_rd_byte at index %0d", i));
            next_cycles(1);
        end
        check_flag(pkt_req, 1'b1, "o_pkt_req after the reads");
        check_len(pkt_len, pkt_rx_pkg::pkt_len_t'(frame_q.size()), "o_pkt_len after the reads");
        check_flag(pkt_crc_ok, exp_ok, "o_pkt_crc_ok after the reads");
        pkt_ack = 1'b1;
        wait_req(1'b0, "o_pkt_req to fall after ack");
        pkt_ack = 1'b0;
        wait_busy_low("o_rx_busy to fall after the handshake");
    endtask

    initial begin
        int                ptr;
        int                len;
        int                n_cases;
        pkt_rx_pkg::byte_t verdict;

        uart_rx = 1'b1; // line idles high
        rd_idx  = '0;
        pkt_ack = 1'b0;
        rng     = 32'h9bd2d4ca;
        ptr     = 0;
        n_cases = 0;
        $readmemh("dv/pkt_cases.txt", case_mem);

        wait_reset_done();
        check_flag(pkt_req, 1'b0, "o_pkt_req after reset");
        check_flag(rx_busy, 1'b0, "o_rx_busy after reset");
        check_flag(pkt_crc_ok, 1'b0, "o_pkt_crc_ok after reset");

        while (ptr < case_words - 66 && case_mem[ptr] != 8'h00) begin
            len = int'(case_mem[ptr]);
            frame_q.delete();
            for (int i = 1; i <= len; i++) begin
                frame_q.push_back(case_mem[ptr + i]);
            end
            verdict = case_mem[ptr + len + 1];
            ptr     = ptr + len + 2;
            send_frame();
            if (verdict == 8'h02) begin
                check_flag(rx_busy, 1'b1, "o_rx_busy while a short frame is collected");
                wait_busy_low("o_rx_busy to fall after a short frame");
            end else begin
                offer_and_ack(verdict == 8'h01);
            end
            n_cases++;
        end

        if (n_cases == 0) begin
            $display("No cases could be read from dv/pkt_cases.txt");
            $display("Regression failed");
            $fatal(1, "no cases");
        end else begin
            $display("%0d cases done", n_cases);
            $display("Regression passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* dv/pkt_cases.txt */
// length in hex, then the frame bytes with the crc lsb first, then the verdict
// verdict 01 good, 00 bad crc, 02 dropped as too short; a length of 00 ends the list
05 61 43 be b7 e8 01
0d 31 32 33 34 35 36 37 38 39 26 39 f4 cb 01
02 aa 55 02
07 61 62 63 c2 41 24 35 01
0d 31 32 33 34 36 36 37 38 39 26 39 f4 cb 00
01 55 02
09 68 65 6c 6c 6f 86 a6 10 36 01
07 61 62 63 c3 41 24 35 00
04 de ad be ef 02
2f 54 68 65 20 71 75 69 63 6b 20 62 72 6f 77 6e 20
   66 6f 78 20 6a 75 6d 70 73 20 6f 76 65 72 20 74
   68 65 20 6c 61 7a 79 20 64 6f 67 39 a3 4f 41 01
03 01 02 03 02
09 68 65 6c 6c 7f 86 a6 10 36 00
05 61 43 be b7 e9 00
00

/* all.f */
common/pkt_rx_pkg.sv
hdl/uart_rx.sv
pkt_rx/frame_collector.sv
pkt_rx/crc32_engine.sv
pkt_rx/pkt_checker.sv
hdl/pkt_rx_top.sv
dv/tb_clk_gen.sv
dv/tb_pkt_rx.sv

/* run.sh */
#!/usr/bin/env bash
# compile and run the packet receiver testbench with verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ns -j 0 \
    --top-module tb_pkt_rx -f all.f -o tb_pkt_rx_sim
status=$?
if [ $status -ne 0 ]; then
    echo "compile step exited with status $status"
    exit $status
fi

./obj_dir/tb_pkt_rx_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit $status
fi

exit 0
